// File: compile.f
+incdir+hdl
hdl/pcb_pkg.sv
hdl/pcb_reg_access.sv
hdl/bufid_free_pool.sv
hdl/bufid_refcount.sv
hdl/bufid_audit.sv
hdl/pcb_top.sv
tests/tb_pcb_top.sv

// File: Bender.yml
package:
  name: pcb_bufid

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pcb_pkg.sv
      - hdl/pcb_reg_access.sv
      - hdl/bufid_free_pool.sv
      - hdl/bufid_refcount.sv
      - hdl/bufid_audit.sv
      - hdl/pcb_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/tb_pcb_top.sv

// File: tests/tb_pcb_top.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module tb_pcb_top;
        import pcb_pkg::*;

        localparam int CLK_HALF    = 10;
        localparam int TIMEOUT_CYC = 3 * `PCB_NUM_BUF + 500;   // fill, two drains, slack

        logic                           clk_sys;
        logic                           reset_n;
        apb_req_t                       apb_req;
        apb_rsp_t                       apb_rsp;
        alloc_t                         alloc;
        logic                           alloc_ack;
        release_t                       rel;
        logic                           rel_ack;
        cnt_set_t                       cnt_set;

        bufid_t                         free_q [$];     // model of the free FIFO
        refcnt_t                        ref_cnt [`PCB_NUM_BUF];
        logic [`PCB_NUM_BUF-1:0]        in_pool;
        logic [`PCB_DATA_W-1:0]         ovf_cnt;
        logic [`PCB_DATA_W-1:0]         udf_cnt;

        logic [31:0]                    lfsr;
        int                             err_cnt;
        int                             chk_cnt;
        int                             test_err;
        int                             cycle_cnt;

        pcb_top u_dut (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_apb          (apb_req),
                .o_apb          (apb_rsp),
                .o_alloc        (alloc),
                .i_alloc_ack    (alloc_ack),
                .i_release      (rel),
                .o_release_ack  (rel_ack),
                .i_cnt_set      (cnt_set)
        );

        always #CLK_HALF clk_sys = ~clk_sys;

        ////////////////////////////////////////////////////////////
        // random bits and reference model
        ////////////////////////////////////////////////////////////

        function automatic logic [31:0] rand_bits(input int n);
                logic [31:0] val;
                val = '0;
                for (int i = 0; i < n; i++) begin
                        val  = {val[30:0], lfsr[0]};
                        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
                end
                return val;
        endfunction

        function automatic void model_push(input bufid_t id);
                if (free_q.size() < `PCB_NUM_BUF) begin         // full pool drops the id
                        if (in_pool[id]) begin
                                ovf_cnt = ovf_cnt + 1;
                        end
                        in_pool[id] = 1'b1;
                        free_q.push_back(id);
                end
        endfunction

        function automatic void model_pop();
                bufid_t id;
                id = free_q.pop_front();
                if (!in_pool[id]) begin
                        udf_cnt = udf_cnt + 1;                  // stale copy
                end
                in_pool[id] = 1'b0;
        endfunction

        function automatic void model_release(input bufid_t id);
                if (ref_cnt[id] <= 1) begin
                        ref_cnt[id] = '0;
                        model_push(id);
                end else begin
                        ref_cnt[id] = ref_cnt[id] - 1'b1;
                end
        endfunction

        function automatic logic [`PCB_DATA_W-1:0] expect_free();
                return `PCB_DATA_W'(free_q.size());
        endfunction

        function automatic bufid_t expect_head();
                return (free_q.size() > 0) ? free_q[0] : '0;
        endfunction

        ////////////////////////////////////////////////////////////
        // compare tasks
        ////////////////////////////////////////////////////////////

        task automatic report_error(input string msg);
                err_cnt++;
                $display("Error at %0t ns: %s", $time, msg);
        endtask

        task automatic check_id(input string name, input bufid_t got, input bufid_t exp);
                chk_cnt++;
                if (got !== exp) begin
                        err_cnt++;
                        $display("Mismatch at %0t ns: %s is %0d, expected %0d",
                                 $time, name, got, exp);
                end
        endtask

        task automatic check_reg(input string name, input logic [`PCB_DATA_W-1:0] got,
                                 input logic [`PCB_DATA_W-1:0] exp);
                chk_cnt++;
                if (got !== exp) begin
                        err_cnt++;
                        $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
                                 $time, name, got, exp);
                end
        endtask

        task automatic check_err(input string name, input logic got, input logic exp);
                chk_cnt++;
                if (got !== exp) begin
                        err_cnt++;
                        $display("Mismatch at %0t ns: %s is %b, expected %b",
                                 $time, name, got, exp);
                end
        endtask

        // every accepted allocation must match the model head
        always @(posedge clk_sys) begin
                if (reset_n && alloc.valid && alloc_ack) begin
                        if (free_q.size() == 0) begin
                                report_error("pool offered an id while the model pool is empty");
                        end else begin
                                check_id("o_alloc.id", alloc.id, expect_head());
                                model_pop();
                        end
                end
        end

        always @(posedge clk_sys) begin
                cycle_cnt++;
                if (cycle_cnt >= TIMEOUT_CYC) begin
                        $display("Error at %0t ns: run stopped after %0d cycles, a test hung",
                                 $time, cycle_cnt);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        ////////////////////////////////////////////////////////////
        // bus and port drivers, all start and end after a falling edge
        ////////////////////////////////////////////////////////////

        task automatic apb_xfer(input logic wr, input logic [`PCB_APB_AW-1:0] addr,
                                input logic [`PCB_DATA_W-1:0] wdata,
                                output logic [`PCB_DATA_W-1:0] rdata, output logic err);
                apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
                @(negedge clk_sys);
                apb_req.penable = 1'b1;                 // access cycle
                @(posedge clk_sys);
                rdata = apb_rsp.prdata;
                err   = apb_rsp.pslverr;
                @(negedge clk_sys);
                apb_req = '0;
        endtask

        task automatic expect_reg(input logic [`PCB_APB_AW-1:0] addr, input string name,
                                  input logic [`PCB_DATA_W-1:0] exp);
                logic [`PCB_DATA_W-1:0] data;
                logic                   err;
                apb_xfer(1'b0, addr, '0, data, err);
                check_reg(name, data, exp);
                check_err("pslverr", err, 1'b0);
        endtask

        task automatic allocate(input int n);
                int taken;
                taken     = 0;
                alloc_ack = 1'b1;
                while (taken < n) begin
                        @(posedge clk_sys);
                        if (alloc.valid) begin
                                taken++;
                        end
                end
                @(negedge clk_sys);
                alloc_ack = 1'b0;
        endtask

        task automatic set_count(input bufid_t id, input refcnt_t cnt);
                cnt_set     = '{wr: 1'b1, id: id, cnt: cnt};
                ref_cnt[id] = cnt;
                @(negedge clk_sys);
                cnt_set = '0;
        endtask

        task automatic release_id(input bufid_t id);
                rel = '{valid: 1'b1, id: id};
                @(posedge clk_sys);
                if (rel_ack !== 1'b1) begin
                        report_error($sformatf("release of id %0d was not acknowledged", id));
                end else begin
                        model_release(id);
                end
                @(negedge clk_sys);
                rel = '0;
        endtask

        task automatic start_test();
                test_err = err_cnt;
        endtask

        task automatic finish_test(input string name);
                if (err_cnt == test_err) begin
                        $display("test %s: ok", name);
                end else begin
                        $display("test %s: %0d errors", name, err_cnt - test_err);
                end
        endtask

        ////////////////////////////////////////////////////////////
        // test sequence
        ////////////////////////////////////////////////////////////

        initial begin
                logic [`PCB_DATA_W-1:0] rd;
                logic                   err;
                refcnt_t                rnd;
                clk_sys   = 1'b0;
                reset_n   = 1'b0;
                apb_req   = '0;
                alloc_ack = 1'b0;
                rel       = '0;
                cnt_set   = '0;
                lfsr      = 32'ha661;
                err_cnt   = 0;
                chk_cnt   = 0;
                cycle_cnt = 0;
                ovf_cnt   = '0;
                udf_cnt   = '0;
                in_pool   = '0;
                repeat (5) @(posedge clk_sys);
                @(negedge clk_sys);
                reset_n = 1'b1;
                for (int i = 0; i < `PCB_NUM_BUF; i++) begin
                        model_push(bufid_t'(i));        // ascending fill
                end

                start_test();
                rd = '0;
                while (rd[0] !== 1'b1) begin
                        apb_xfer(1'b0, `PCB_REG_STATUS, '0, rd, err);
                end
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                allocate(4);
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                finish_test("1 fill and first allocations");

                start_test();
                rnd = refcnt_t'(2 + rand_bits(4) % 14);
                set_count(0, rnd);
                repeat (rnd - 1) release_id(0);
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                release_id(0);                          // last reference
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                finish_test($sformatf("2 multi-reference release, count %0d", rnd));

                start_test();
                set_count(1, 1);
                release_id(1);
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                set_count(2, 0);
                release_id(2);
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                finish_test("3 single-reference releases");

                start_test();
                allocate(1);                            // room for the second copy
                set_count(3, 0);
                release_id(3);
                release_id(3);
                expect_reg(`PCB_REG_OVF, "overflow count", ovf_cnt);
                expect_reg(`PCB_REG_UDF, "underflow count", udf_cnt);
                allocate(free_q.size());
                check_err("o_alloc.valid", alloc.valid, free_q.size() != 0);
                expect_reg(`PCB_REG_UDF, "underflow count", udf_cnt);
                expect_reg(`PCB_REG_FREE, "free count", expect_free());
                finish_test("4 double release and drain");

                start_test();
                apb_xfer(1'b1, `PCB_REG_OVF, '1, rd, err);
                check_err("pslverr", err, 1'b0);
                ovf_cnt = '0;
                apb_xfer(1'b1, `PCB_REG_UDF, '1, rd, err);
                check_err("pslverr", err, 1'b0);
                udf_cnt = '0;
                expect_reg(`PCB_REG_OVF, "overflow count", ovf_cnt);
                expect_reg(`PCB_REG_UDF, "underflow count", udf_cnt);
                apb_xfer(1'b0, 4'h2, '0, rd, err);      // unaligned hole
                check_reg("prdata", rd, '0);
                check_err("pslverr", err, 1'b1);
                finish_test("5 counter clear and unmapped read");

                $display("checks %0d, errors %0d", chk_cnt, err_cnt);
                if (err_cnt == 0) begin
                        $display(">>> PASS");
                end else begin
                        $display(">>> FAIL");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: hdl/pcb_top.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module pcb_top (
        input  wire                             clk_sys,
        input  wire                             reset_n,
        input  wire pcb_pkg::apb_req_t          i_apb,
        output pcb_pkg::apb_rsp_t               o_apb,
        output pcb_pkg::alloc_t                 o_alloc,
        input  wire                             i_alloc_ack,
        input  wire pcb_pkg::release_t          i_release,
        output logic                            o_release_ack,
        input  wire pcb_pkg::cnt_set_t          i_cnt_set
);
        import pcb_pkg::*;

        logic                   ret_push;       // refcount to pool
        bufid_t                 ret_id;
        pool_op_t               pool_op;        // pool to audit
        logic                   init_done;
        logic [`PCB_ID_W:0]     free_cnt;
        audit_cnt_t             audit_cnt;
        audit_clr_t             audit_clr;

        ////////////////////////////////////////////////////////////
        // register decode
        ////////////////////////////////////////////////////////////

        pcb_reg_access u_reg_access (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_apb          (i_apb),
                .o_apb          (o_apb),
                .i_init_done    (init_done),
                .i_free_cnt     (free_cnt),
                .i_audit        (audit_cnt),
                .o_clr          (audit_clr)
        );

        ////////////////////////////////////////////////////////////
        // allocate and release
        ////////////////////////////////////////////////////////////

        bufid_free_pool u_free_pool (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_push         (ret_push),
                .i_push_id      (ret_id),
                .o_alloc        (o_alloc),
                .i_alloc_ack    (i_alloc_ack),
                .o_pool_op      (pool_op),
                .o_init_done    (init_done),
                .o_free_cnt     (free_cnt)
        );

        bufid_refcount u_refcount (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_cnt_set      (i_cnt_set),
                .i_release      (i_release),
                .o_release_ack  (o_release_ack),
                .i_run          (init_done),
                .o_push         (ret_push),
                .o_push_id      (ret_id)
        );

        bufid_audit u_audit (
                .clk_sys        (clk_sys),
                .reset_n        (reset_n),
                .i_pool_op      (pool_op),
                .i_clr          (audit_clr),
                .o_cnt          (audit_cnt)
        );

endmodule

`default_nettype wire

// File: hdl/bufid_audit.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module bufid_audit (
        input  wire                             clk_sys,
        input  wire                             reset_n,
        input  wire pcb_pkg::pool_op_t          i_pool_op,
        input  wire pcb_pkg::audit_clr_t        i_clr,
        output pcb_pkg::audit_cnt_t             o_cnt
);
        import pcb_pkg::*;

        logic [`PCB_NUM_BUF-1:0]        bitmap;         // one bit per id held in the pool
        logic                           push_set;
        logic                           pop_set;
        logic                           same_id;

        assign push_set = bitmap[i_pool_op.push_id];
        assign pop_set  = bitmap[i_pool_op.pop_id];
        assign same_id  = i_pool_op.push && i_pool_op.pop &&
                          (i_pool_op.push_id == i_pool_op.pop_id);

        ////////////////////////////////////////////////////////////
        // membership
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        bitmap <= '0;
                end else if (!same_id) begin            // in and out again, bit stays
                        if (i_pool_op.push) begin
                                bitmap[i_pool_op.push_id] <= 1'b1;
                        end
                        if (i_pool_op.pop) begin
                                bitmap[i_pool_op.pop_id] <= 1'b0;
                        end
                end
        end

        ////////////////////////////////////////////////////////////
        // error counters
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        o_cnt <= '0;
                end else begin
                        if (i_clr.ovf) begin
                                o_cnt.ovf <= '0;
                        end else if (i_pool_op.push && push_set) begin
                                o_cnt.ovf <= o_cnt.ovf + 1'b1;  // id already free
                        end
                        if (i_clr.udf) begin
                                o_cnt.udf <= '0;
                        end else if (i_pool_op.pop && !pop_set) begin
                                o_cnt.udf <= o_cnt.udf + 1'b1;  // id not in pool
                        end
                end
        end

endmodule

`default_nettype wire

// File: hdl/bufid_refcount.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module bufid_refcount (
        input  wire                             clk_sys,
        input  wire                             reset_n,
        input  wire pcb_pkg::cnt_set_t          i_cnt_set,
        input  wire pcb_pkg::release_t          i_release,
        output logic                            o_release_ack,
        input  wire                             i_run,
        output logic                            o_push,
        output pcb_pkg::bufid_t                 o_push_id
);
        import pcb_pkg::*;

        refcnt_t        cnt_mem [`PCB_NUM_BUF];
        refcnt_t        cur_cnt;
        logic           last_ref;

        assign cur_cnt  = cnt_mem[i_release.id];
        assign last_ref = (cur_cnt <= refcnt_t'(1));    // 0 counts as a single copy

        ////////////////////////////////////////////////////////////
        // release decision
        ////////////////////////////////////////////////////////////

        assign o_release_ack = i_release.valid && i_run;        // held off during the fill
        assign o_push        = o_release_ack && last_ref;
        assign o_push_id     = i_release.id;

        always_ff @(posedge clk_sys) begin
                if (i_cnt_set.wr) begin
                        cnt_mem[i_cnt_set.id] <= i_cnt_set.cnt; // lookup table copy count
                end
                if (o_release_ack) begin
                        if (last_ref) begin
                                cnt_mem[i_release.id] <= '0;
                        end else begin
                                cnt_mem[i_release.id] <= cur_cnt - 1'b1;
                        end
                end
        end

        // both would write the same entry in one edge
        no_set_release_clash: assert property (
                @(posedge clk_sys) disable iff (!reset_n)
                (i_cnt_set.wr && i_release.valid) |-> (i_cnt_set.id != i_release.id));

endmodule

`default_nettype wire

// File: hdl/bufid_free_pool.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module bufid_free_pool (
        input  wire                             clk_sys,
        input  wire                             reset_n,
        input  wire                             i_push,
        input  wire pcb_pkg::bufid_t            i_push_id,
        output pcb_pkg::alloc_t                 o_alloc,
        input  wire                             i_alloc_ack,
        output pcb_pkg::pool_op_t               o_pool_op,
        output logic                            o_init_done,
        output logic [`PCB_ID_W:0]              o_free_cnt
);
        import pcb_pkg::*;

        pool_state_e            state;
        bufid_t                 mem [`PCB_NUM_BUF];
        bufid_t                 wr_ptr;
        bufid_t                 rd_ptr;
        logic [`PCB_ID_W:0]     count;
        logic                   full;
        logic                   push_en;
        bufid_t                 push_id;
        logic                   pop;
        bufid_t                 head_id;

        assign full    = (count == `PCB_NUM_BUF);
        // during the fill the write pointer doubles as the next id
        assign push_en = (state == POOL_INIT) || (i_push && !full);
        assign push_id = (state == POOL_INIT) ? wr_ptr : i_push_id;
        assign head_id = mem[rd_ptr];
        assign pop     = o_alloc.valid && i_alloc_ack;

        ////////////////////////////////////////////////////////////
        // fill sequence
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        state <= POOL_INIT;
                end else if (state == POOL_INIT && wr_ptr == bufid_t'(`PCB_NUM_BUF - 1)) begin
                        state <= POOL_RUN;              // last id goes in this edge
                end
        end

        ////////////////////////////////////////////////////////////
        // FIFO
        ////////////////////////////////////////////////////////////

        always_ff @(posedge clk_sys) begin
                if (push_en) begin
                        mem[wr_ptr] <= push_id;
                end
        end

        always_ff @(posedge clk_sys or negedge reset_n) begin
                if (!reset_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push_en) begin
                                wr_ptr <= wr_ptr + 1'b1;        // wraps at the pool size
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({push_en, pop})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;                // idle or push with pop
                        endcase
                end
        end

        assign o_alloc     = '{valid: (state == POOL_RUN) && (count != '0), id: head_id};
        assign o_pool_op   = '{push: push_en, push_id: push_id, pop: pop, pop_id: head_id};
        assign o_init_done = (state == POOL_RUN);
        assign o_free_cnt  = count;

        // an ack with no offer would pop an empty pool
        no_pop_when_empty: assert property (
                @(posedge clk_sys) disable iff (!reset_n)
                i_alloc_ack |-> o_alloc.valid);

        no_return_in_fill: assert property (
                @(posedge clk_sys) disable iff (!reset_n)
                i_push |-> o_init_done);

endmodule

`default_nettype wire

// File: hdl/pcb_reg_access.sv
`timescale 1ns/1ns
`include "pcb_params.svh"
`default_nettype none

module pcb_reg_access (
        input  wire                             clk_sys,
        input  wire                             reset_n,
        input  wire pcb_pkg::apb_req_t          i_apb,
        output pcb_pkg::apb_rsp_t               o_apb,
        input  wire                             i_init_done,
        input  wire [`PCB_ID_W:0]               i_free_cnt,
        input  wire pcb_pkg::audit_cnt_t        i_audit,
        output pcb_pkg::audit_clr_t             o_clr
);
        import pcb_pkg::*;

        logic                           access;
        logic                           wr_access;
        reg_addr_e                      addr;
        logic                           mapped;
        logic [`PCB_DATA_W-1:0]         rd_val;
        logic [`PCB_DATA_W-1:0]         rd_data;

        assign access    = i_apb.psel && i_apb.penable;         // second APB phase
        assign wr_access = access && i_apb.pwrite;
        assign addr      = reg_addr_e'(i_apb.paddr);

        ////////////////////////////////////////////////////////////
        // read mux
        ////////////////////////////////////////////////////////////

        always_comb begin
                mapped = 1'b1;
                rd_val = '0;
                case (addr)
                REG_STATUS: rd_val = {{(`PCB_DATA_W-1){1'b0}}, i_init_done};
                REG_FREE:   rd_val = {{(`PCB_DATA_W-`PCB_ID_W-1){1'b0}}, i_free_cnt};
                REG_OVF:    rd_val = i_audit.ovf;
                REG_UDF:    rd_val = i_audit.udf;
                default:    mapped = 1'b0;              // holes and unaligned offsets
                endcase
        end

        assign rd_data = (access && !i_apb.pwrite) ? rd_val : '0;

        assign o_apb = '{prdata: rd_data, pslverr: access && !mapped};

        // no wait states, so the strobe is high for exactly one cycle
        assign o_clr = '{ovf: wr_access && (addr == REG_OVF),
                         udf: wr_access && (addr == REG_UDF)};

        ////////////////////////////////////////////////////////////
        // bus protocol
        ////////////////////////////////////////////////////////////

        penable_needs_psel: assert property (
                @(posedge clk_sys) disable iff (!reset_n)
                $rose(i_apb.penable) |-> i_apb.psel);

endmodule

`default_nettype wire

// File: hdl/pcb_pkg.sv
`include "pcb_params.svh"
`default_nettype none

package pcb_pkg;

        typedef logic [`PCB_ID_W-1:0]   bufid_t;
        typedef logic [`PCB_CNT_W-1:0]  refcnt_t;

        ////////////////////////////////////////////////////////////
        // id traffic
        ////////////////////////////////////////////////////////////

        typedef struct packed {
                logic           valid;
                bufid_t         id;             // pool head
        } alloc_t;

        typedef struct packed {
                logic           valid;
                bufid_t         id;             // id handed back by a port
        } release_t;

        typedef struct packed {
                logic           wr;
                bufid_t         id;
                refcnt_t        cnt;            // number of outgoing copies
        } cnt_set_t;

        typedef struct packed {
                logic           push;
                bufid_t         push_id;
                logic           pop;
                bufid_t         pop_id;
        } pool_op_t;

        ////////////////////////////////////////////////////////////
        // register side
        ////////////////////////////////////////////////////////////

        typedef struct packed {
                logic                           psel;
                logic                           penable;
                logic                           pwrite;
                logic [`PCB_APB_AW-1:0]         paddr;
                logic [`PCB_DATA_W-1:0]         pwdata;
        } apb_req_t;

        typedef struct packed {
                logic [`PCB_DATA_W-1:0]         prdata;
                logic                           pslverr;
        } apb_rsp_t;

        typedef struct packed {
                logic [`PCB_DATA_W-1:0]         ovf;
                logic [`PCB_DATA_W-1:0]         udf;
        } audit_cnt_t;

        typedef struct packed {
                logic                           ovf;
                logic                           udf;
        } audit_clr_t;

        typedef enum logic {
                POOL_INIT,                      // writing ids 0 .. N-1
                POOL_RUN
        } pool_state_e;

        typedef enum logic [`PCB_APB_AW-1:0] {
                REG_STATUS      = `PCB_REG_STATUS,
                REG_FREE        = `PCB_REG_FREE,
                REG_OVF         = `PCB_REG_OVF,
                REG_UDF         = `PCB_REG_UDF
        } reg_addr_e;

endpackage

`default_nettype wire

// File: hdl/pcb_params.svh
`ifndef PCB_PARAMS_SVH
`define PCB_PARAMS_SVH

////////////////////////////////////////////////////////////
// buffer pool geometry
////////////////////////////////////////////////////////////

`define PCB_NUM_BUF     512             // buffer ids in the pool
`define PCB_ID_W        9               // log2 of the buffer count
`define PCB_CNT_W       4               // reference count width

////////////////////////////////////////////////////////////
// register access
////////////////////////////////////////////////////////////

`define PCB_APB_AW      4               // byte address, four word registers
`define PCB_DATA_W      32

`define PCB_REG_STATUS  4'h0            // bit 0 is init done
`define PCB_REG_FREE    4'h4            // ids held in the pool
`define PCB_REG_OVF     4'h8            // double push count
`define PCB_REG_UDF     4'hC            // stale pop count

`endif
